// ==== list.f ====
verilog/rp_pkg.sv
verilog/rp_mix_if.sv
verilog/rp_startup_fsm.sv
verilog/rp_pwm_timer.sv
verilog/rp_pwm_dac.sv
verilog/rp_adc_frontend.sv
verilog/rp_dac_backend.sv
verilog/rp_top.sv
dv/rp_top_sva.sv
dv/tb_rp_top.sv

// ==== Bender.yml ====
package:
  name: rp_top

sources:
  - verilog/rp_pkg.sv
  - verilog/rp_mix_if.sv
  - verilog/rp_startup_fsm.sv
  - verilog/rp_pwm_timer.sv
  - verilog/rp_pwm_dac.sv
  - verilog/rp_adc_frontend.sv
  - verilog/rp_dac_backend.sv
  - verilog/rp_top.sv
  - target: test
    files:
      - dv/rp_top_sva.sv
      - dv/tb_rp_top.sv

// ==== dv/tb_rp_top.sv ====
// Converter datapath testbench
// Directed tests for startup, ADC conversion, DAC mixing, loopback and PWM

module tb_rp_top;

  localparam int unsigned CLK_PERIOD = 40;
  localparam int unsigned SETTLE     = 16;
  localparam int unsigned NUM_PWM    = 4;
  localparam int unsigned N_RAND     = 32;  // Samples per random test
  localparam int unsigned N_MIX      = 11;  // Held mix pairs
  // Rough cycle budget of all tests
  localparam int unsigned TEST_CYCLES = 4 + 90 + N_RAND + 3 * N_MIX + N_RAND + 2 * 256;
  localparam int unsigned WATCHDOG_CYCLES = 5 * TEST_CYCLES + 500;  // Wide margin on top

  logic adc_clk = 1'b0;
  logic rst_i;
  logic pll_locked_i;
  logic digital_loop_i;
  rp_pkg::raw_adc_t adc_a_i;
  rp_pkg::raw_adc_t adc_b_i;
  rp_pkg::sample_t  adc_a_o;
  rp_pkg::sample_t  adc_b_o;
  rp_pkg::sample_t  asg_a_i;
  rp_pkg::sample_t  asg_b_i;
  rp_pkg::sample_t  pid_a_i;
  rp_pkg::sample_t  pid_b_i;
  rp_pkg::dac_code_t dac_dat_o;
  logic dac_sel_o;
  logic dac_rst_o;
  logic run_o;
  rp_pkg::duty_t [NUM_PWM-1:0] pwm_duty_i;
  logic          [NUM_PWM-1:0] dac_pwm_o;

  integer seed = 32'h4e189499;
  int     checks = 0;
  int     errors = 0;

  rp_top #(.SETTLE_CYCLES(SETTLE), .NUM_PWM(NUM_PWM)) i_dut (.*);

  always #(CLK_PERIOD / 2) adc_clk = ~adc_clk;

  // Next drive point just after the rising edge
  task automatic tick();
    @(posedge adc_clk);
    #5;
  endtask

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_sample(input rp_pkg::sample_t got, input rp_pkg::sample_t exp,
                              input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s, got %0d expected %0d", $time, msg, got, exp);
    end
  endtask

  task automatic check_code(input rp_pkg::dac_code_t got, input rp_pkg::dac_code_t exp,
                            input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s, got %b expected %b", $time, msg, got, exp);
    end
  endtask

  task automatic check_duty(input rp_pkg::duty_t got, input rp_pkg::duty_t exp,
                            input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s, got %0d expected %0d", $time, msg, got, exp);
    end
  endtask

  // Reference sum clamped to the 14-bit signed range
  function automatic rp_pkg::sample_t sat_sum(input rp_pkg::sample_t x,
                                              input rp_pkg::sample_t y);
    int s;
    s = int'(x) + int'(y);
    if (s > 8191)
      s = 8191;
    else if (s < -8192)
      s = -8192;
    return rp_pkg::sample_t'(s);
  endfunction

  task automatic wait_for_run();
    int n = 0;
    while (!run_o && n < 64) begin
      tick();
      n++;
    end
    if (!run_o) begin
      errors++;
      $display("run_o did not go high within 64 cycles of PLL lock");
    end
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic startup_sequence();
    pll_locked_i = 1'b0;
    repeat (8) begin
      tick();
      check_bit(run_o, 1'b0, "run_o before lock");
      check_bit(dac_rst_o, 1'b1, "dac_rst_o before lock");
      check_bit(dac_sel_o, 1'b0, "dac_sel_o before lock");
      check_code(dac_dat_o, 14'h1FFF, "idle DAC code");
    end
    pll_locked_i = 1'b1;
    for (int i = 1; i <= SETTLE + 1; i++) begin  // Lock cycle then settle
      tick();
      check_bit(run_o, i == SETTLE + 1, "run_o through settle");
    end
    check_bit(dac_rst_o, 1'b0, "dac_rst_o in run");
    check_bit(dac_sel_o, 1'b0, "dac_sel_o in first run cycle");
    pll_locked_i = 1'b0;
    tick();
    check_bit(run_o, 1'b0, "run_o after lock loss");
    check_bit(dac_rst_o, 1'b1, "dac_rst_o after lock loss");
    pll_locked_i = 1'b1;  // Back to run for the later tests
    wait_for_run();
  endtask

  task automatic adc_conversion();
    rp_pkg::sample_t exp_a;
    rp_pkg::sample_t exp_b;
    digital_loop_i = 1'b0;
    repeat (N_RAND) begin
      adc_a_i = rp_pkg::raw_adc_t'($random(seed));
      adc_b_i = rp_pkg::raw_adc_t'($random(seed));
      exp_a   = adc_a_i[15:2] ^ 14'h1FFF;  // Sign kept and rest inverted
      exp_b   = adc_b_i[15:2] ^ 14'h1FFF;
      tick();
      check_sample(adc_a_o, exp_a, "ADC channel A");
      check_sample(adc_b_o, exp_b, "ADC channel B");
    end
  endtask

  // Hold one pair per channel over both interleave phases
  task automatic hold_mix(input rp_pkg::sample_t ga, input rp_pkg::sample_t pa,
                          input rp_pkg::sample_t gb, input rp_pkg::sample_t pb);
    rp_pkg::dac_code_t code_a;
    rp_pkg::dac_code_t code_b;
    logic              sel_first;
    code_a  = sat_sum(ga, pa) ^ 14'h1FFF;
    code_b  = sat_sum(gb, pb) ^ 14'h1FFF;
    asg_a_i = ga;
    pid_a_i = pa;
    asg_b_i = gb;
    pid_b_i = pb;
    tick();
    sel_first = dac_sel_o;
    check_code(dac_dat_o, sel_first ? code_a : code_b, "interleaved DAC code");
    tick();
    check_bit(dac_sel_o, ~sel_first, "dac_sel_o alternates");
    check_code(dac_dat_o, sel_first ? code_b : code_a, "interleaved DAC code");
  endtask

  task automatic dac_mixing();
    hold_mix(14'sd8000, 14'sd500, -14'sd8000, -14'sd500);  // Both rails
    hold_mix(14'h2000, -14'sd1, 14'sd8191, 14'sd1);        // Off by one past each rail
    hold_mix(14'sd8191, 14'h2000, 14'sd0, 14'sd0);         // Full span and mid-scale
    repeat (N_MIX - 3)
      hold_mix(rp_pkg::sample_t'($random(seed)), rp_pkg::sample_t'($random(seed)),
               rp_pkg::sample_t'($random(seed)), rp_pkg::sample_t'($random(seed)));
  endtask

  task automatic digital_loopback();
    rp_pkg::sample_t exp_a;
    rp_pkg::sample_t exp_b;
    digital_loop_i = 1'b1;
    repeat (N_RAND) begin
      asg_a_i = rp_pkg::sample_t'($random(seed));
      pid_a_i = rp_pkg::sample_t'($random(seed));
      asg_b_i = rp_pkg::sample_t'($random(seed));
      pid_b_i = rp_pkg::sample_t'($random(seed));
      adc_a_i = rp_pkg::raw_adc_t'($random(seed));  // Must be ignored
      adc_b_i = rp_pkg::raw_adc_t'($random(seed));
      exp_a   = sat_sum(asg_a_i, pid_a_i);
      exp_b   = sat_sum(asg_b_i, pid_b_i);
      tick();
      check_sample(adc_a_o, exp_a, "loopback channel A");
      check_sample(adc_b_o, exp_b, "loopback channel B");
    end
    digital_loop_i = 1'b0;
  endtask

  task automatic pwm_periods();
    int high_cnt [NUM_PWM] = '{default: 0};
    pwm_duty_i[0] = 8'd0;
    pwm_duty_i[1] = 8'd255;
    pwm_duty_i[2] = 8'd1;
    pwm_duty_i[3] = 8'd100;
    repeat (256) tick();  // One full period so the new words are latched
    repeat (256) begin
      tick();
      for (int n = 0; n < NUM_PWM; n++)
        high_cnt[n] += dac_pwm_o[n];
    end
    for (int n = 0; n < NUM_PWM; n++)
      check_duty(rp_pkg::duty_t'(high_cnt[n]), pwm_duty_i[n],
                 $sformatf("PWM channel %0d high cycles", n));
  endtask

  //////////////////////////////
  // Sequence and watchdog
  //////////////////////////////

  initial begin
    rst_i          = 1'b1;
    pll_locked_i   = 1'b0;
    digital_loop_i = 1'b0;
    adc_a_i        = '0;
    adc_b_i        = '0;
    asg_a_i        = '0;
    asg_b_i        = '0;
    pid_a_i        = '0;
    pid_b_i        = '0;
    pwm_duty_i     = '0;
    repeat (4) tick();
    rst_i = 1'b0;
    startup_sequence();
    adc_conversion();
    dac_mixing();
    digital_loopback();
    pwm_periods();
    $display("Summary: %0d checks, %0d errors, %0d assertion failures",
             checks, errors, i_dut.i_sva.fail_cnt);
    if (errors == 0 && i_dut.i_sva.fail_cnt == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== dv/rp_top_sva.sv ====
// Converter datapath protocol checks
// Bound into rp_top to cover sequencing and DAC output behavior

module rp_top_sva #(
  parameter int unsigned NUM_PWM = 4
) (
  input logic               adc_clk,
  input logic               rst_i,
  input logic               run_o,
  input logic               dac_rst_o,
  input logic               dac_sel_o,
  input logic [NUM_PWM-1:0] dac_pwm_o
);

  int unsigned fail_cnt = 0;  // Failed assertions so far

  // Channel select alternates on every running cycle
  sel_toggle_a: assert property (@(posedge adc_clk) disable iff (rst_i)
    run_o && $past(run_o) |-> dac_sel_o != $past(dac_sel_o))
    else begin
      fail_cnt++;
      $error("dac_sel_o held its value while running");
    end

  // DAC leaves reset only when the datapath runs
  rst_run_a: assert property (@(posedge adc_clk) disable iff (rst_i)
    !(dac_rst_o && run_o))
    else begin
      fail_cnt++;
      $error("dac_rst_o and run_o high together");
    end

  pwm_idle_a: assert property (@(posedge adc_clk) disable iff (rst_i)
    !run_o |-> dac_pwm_o == '0)  // Quiet PWM outside run
    else begin
      fail_cnt++;
      $error("dac_pwm_o active while not running");
    end

endmodule

bind rp_top rp_top_sva #(.NUM_PWM(NUM_PWM)) i_sva (
  .adc_clk   (adc_clk),
  .rst_i     (rst_i),
  .run_o     (run_o),
  .dac_rst_o (dac_rst_o),
  .dac_sel_o (dac_sel_o),
  .dac_pwm_o (dac_pwm_o)
);

// ==== verilog/rp_top.sv ====
// Converter datapath top level
// ADC front end, DAC back end, PWM DACs and startup sequencing on adc_clk

module rp_top #(
  parameter int unsigned SETTLE_CYCLES = 16,  // Settle time after PLL lock
  parameter int unsigned NUM_PWM       = 4    // PWM DAC channels
) (
  input  logic                        adc_clk,
  input  logic                        rst_i,
  input  logic                        pll_locked_i,
  input  logic                        digital_loop_i,  // DAC to ADC loopback
  // ADC
  input  rp_pkg::raw_adc_t            adc_a_i,
  input  rp_pkg::raw_adc_t            adc_b_i,
  output rp_pkg::sample_t             adc_a_o,         // Scope taps here
  output rp_pkg::sample_t             adc_b_o,
  // Generator and controller samples
  input  rp_pkg::sample_t             asg_a_i,
  input  rp_pkg::sample_t             asg_b_i,
  input  rp_pkg::sample_t             pid_a_i,
  input  rp_pkg::sample_t             pid_b_i,
  // DAC
  output rp_pkg::dac_code_t           dac_dat_o,
  output logic                        dac_sel_o,
  output logic                        dac_rst_o,
  output logic                        run_o,
  // PWM DAC
  input  rp_pkg::duty_t [NUM_PWM-1:0] pwm_duty_i,
  output logic          [NUM_PWM-1:0] dac_pwm_o
);

  logic          run;
  rp_pkg::duty_t pwm_cnt;
  logic          period_start;

  rp_mix_if mix ();

  // Sources onto the mixing bus
  assign mix.asg_a = asg_a_i;
  assign mix.asg_b = asg_b_i;
  assign mix.pid_a = pid_a_i;
  assign mix.pid_b = pid_b_i;
  assign run_o     = run;

  //////////////////////////////
  // Sequencing and PWM
  //////////////////////////////

  rp_startup_fsm #(.SETTLE_CYCLES(SETTLE_CYCLES)) i_fsm (
    .adc_clk      (adc_clk),
    .rst_i        (rst_i),
    .pll_locked_i (pll_locked_i),
    .run_o        (run),
    .dac_rst_o    (dac_rst_o)
  );

  rp_pwm_timer i_pwm_timer (
    .adc_clk        (adc_clk),
    .rst_i          (rst_i),
    .run_i          (run),
    .cnt_o          (pwm_cnt),
    .period_start_o (period_start)
  );

  rp_pwm_dac #(.NUM_PWM(NUM_PWM)) i_pwm_dac (
    .adc_clk        (adc_clk),
    .rst_i          (rst_i),
    .run_i          (run),
    .cnt_i          (pwm_cnt),
    .period_start_i (period_start),
    .duty_i         (pwm_duty_i),
    .pwm_o          (dac_pwm_o)
  );

  //////////////////////////////
  // Converter paths
  //////////////////////////////

  rp_adc_frontend i_adc (
    .adc_clk        (adc_clk),
    .rst_i          (rst_i),
    .adc_a_i        (adc_a_i),
    .adc_b_i        (adc_b_i),
    .digital_loop_i (digital_loop_i),
    .mix            (mix),
    .adc_a_o        (adc_a_o),
    .adc_b_o        (adc_b_o)
  );

  rp_dac_backend i_dac (
    .adc_clk   (adc_clk),
    .rst_i     (rst_i),
    .run_i     (run),
    .mix       (mix),
    .dac_dat_o (dac_dat_o),
    .dac_sel_o (dac_sel_o)
  );

endmodule

// ==== verilog/rp_dac_backend.sv ====
// DAC back end
// Sums generator and controller, saturates, converts to DAC code, interleaves A/B

module rp_dac_backend (
  input  logic              adc_clk,
  input  logic              rst_i,
  input  logic              run_i,      // Output gating
  rp_mix_if.mix             mix,        // ASG/PID in, saturated sums out
  output rp_pkg::dac_code_t dac_dat_o,  // Interleaved DAC data
  output logic              dac_sel_o   // High = channel A on dac_dat_o
);

  localparam rp_pkg::dac_code_t ZERO_CODE = 14'h1FFF;  // Mid-scale, sample 0

  logic signed [rp_pkg::SUM_W-1:0] sum_a;
  logic signed [rp_pkg::SUM_W-1:0] sum_b;
  rp_pkg::dac_code_t               code_a_q;
  rp_pkg::dac_code_t               code_b_q;
  logic                            phase_q;   // Channel phase while running

  // Clamp 15-bit sum into 14 bits
  // Top two bits differ means overflow, sign picks the rail
  function automatic rp_pkg::sample_t saturate(input logic [rp_pkg::SUM_W-1:0] sum);
    logic sgn;
    sgn = sum[rp_pkg::SUM_W-1];
    if (sum[rp_pkg::SUM_W-1] ^ sum[rp_pkg::SUM_W-2])
      saturate = {sgn, {(rp_pkg::SMP_W-1){~sgn}}};  // 8191 or -8192
    else
      saturate = sum[rp_pkg::SMP_W-1:0];
  endfunction

  // Two's complement to negative slope code
  function automatic rp_pkg::dac_code_t to_code(input rp_pkg::sample_t smp);
    to_code = {smp[rp_pkg::SMP_W-1], ~smp[rp_pkg::SMP_W-2:0]};
  endfunction

  //////////////////////////////
  // Mix and saturate
  //////////////////////////////

  assign sum_a     = mix.asg_a + mix.pid_a;  // Sign extended to SUM_W
  assign sum_b     = mix.asg_b + mix.pid_b;
  assign mix.dac_a = saturate(sum_a);
  assign mix.dac_b = saturate(sum_b);

  // Output code registers
  always_ff @(posedge adc_clk) begin
    code_a_q <= to_code(mix.dac_a);
    code_b_q <= to_code(mix.dac_b);
  end

  //////////////////////////////
  // Interleave
  //////////////////////////////

  // Phase toggles while running, parked low otherwise
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      phase_q <= 1'b0;
    end else if (run_i) begin
      phase_q <= ~phase_q;
    end else begin
      phase_q <= 1'b0;
    end
  end

  assign dac_sel_o = run_i & phase_q;  // Low in first run cycle

  always_comb begin
    if (!run_i)
      dac_dat_o = ZERO_CODE;           // Idle at mid-scale
    else if (phase_q)
      dac_dat_o = code_a_q;
    else
      dac_dat_o = code_b_q;
  end

endmodule

// ==== verilog/rp_adc_frontend.sv ====
// ADC front end
// Captures both ADC words, converts to two's complement, optional DAC loopback

module rp_adc_frontend (
  input  logic             adc_clk,
  input  logic             rst_i,
  input  rp_pkg::raw_adc_t adc_a_i,         // Channel A raw word
  input  rp_pkg::raw_adc_t adc_b_i,         // Channel B raw word
  input  logic             digital_loop_i,  // Take DAC sums instead of ADC
  rp_mix_if.loop           mix,             // Saturated DAC sums
  output rp_pkg::sample_t  adc_a_o,
  output rp_pkg::sample_t  adc_b_o
);

  rp_pkg::sample_t smp_a;
  rp_pkg::sample_t smp_b;

  // Negative slope to two's complement
  // Top 14 bits kept, sign stays, lower 13 inverted
  function automatic rp_pkg::sample_t to_sample(input rp_pkg::raw_adc_t raw);
    logic [rp_pkg::SMP_W-1:0] top;
    top       = raw[rp_pkg::ADC_RAW_W-1 -: rp_pkg::SMP_W];  // Drop reserved LSBs
    to_sample = {top[rp_pkg::SMP_W-1], ~top[rp_pkg::SMP_W-2:0]};
  endfunction

  //////////////////////////////
  // Source select
  //////////////////////////////

  always_comb begin
    if (digital_loop_i) begin
      smp_a = mix.dac_a;  // Loopback from generate path
      smp_b = mix.dac_b;
    end else begin
      smp_a = to_sample(adc_a_i);
      smp_b = to_sample(adc_b_i);
    end
  end

  // Single register stage, one cycle latency either way
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      adc_a_o <= '0;
      adc_b_o <= '0;
    end else begin
      adc_a_o <= smp_a;
      adc_b_o <= smp_b;
    end
  end

endmodule

// ==== verilog/rp_pwm_dac.sv ====
// Multi-channel PWM DAC
// Duty words latched once per period and compared against the shared count

module rp_pwm_dac #(
  parameter int unsigned NUM_PWM = 4
) (
  input  logic                        adc_clk,
  input  logic                        rst_i,
  input  logic                        run_i,
  input  rp_pkg::duty_t               cnt_i,           // Shared period count
  input  logic                        period_start_i,  // Duty update strobe
  input  rp_pkg::duty_t [NUM_PWM-1:0] duty_i,          // Requested duty per channel
  output logic          [NUM_PWM-1:0] pwm_o
);

  rp_pkg::duty_t [NUM_PWM-1:0] duty_q;    // Duty in force for this period
  rp_pkg::duty_t [NUM_PWM-1:0] duty_cur;  // Duty seen by the compare

  // Latch new duty only at period start, no mid-period glitch
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      duty_q <= '0;
    end else if (period_start_i) begin
      duty_q <= duty_i;
    end
  end

  //////////////////////////////
  // Compare
  //////////////////////////////

  always_comb begin
    for (int n = 0; n < NUM_PWM; n++) begin
      // Count 0 is the latch cycle itself, use the incoming word there
      duty_cur[n] = period_start_i ? duty_i[n] : duty_q[n];
      // High for counts 0..duty-1, exactly duty cycles per period
      pwm_o[n]    = run_i && (cnt_i < duty_cur[n]);
    end
  end

endmodule

// ==== verilog/rp_pwm_timer.sv ====
// PWM period timer
// Free-running 256-cycle counter with a period start strobe

module rp_pwm_timer (
  input  logic          adc_clk,
  input  logic          rst_i,
  input  logic          run_i,          // Count only while running
  output rp_pkg::duty_t cnt_o,          // Position within the period
  output logic          period_start_o  // First cycle of a period
);

  rp_pkg::duty_t cnt_q;

  //////////////////////////////
  // Period counter
  //////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (run_i) begin
      cnt_q <= cnt_q + 8'd1;  // Wraps 255 -> 0
    end else begin
      cnt_q <= '0;            // Parked at zero, next period starts clean
    end
  end

  assign cnt_o = cnt_q;

  // Strobe on count zero, only when live
  assign period_start_o = run_i && (cnt_q == '0);

endmodule

// ==== verilog/rp_startup_fsm.sv ====
// Startup sequencer
// Waits for PLL lock plus a settle time, then enables the datapath

module rp_startup_fsm #(
  parameter int unsigned SETTLE_CYCLES = 16  // Cycles spent in settle, > 0
) (
  input  logic adc_clk,
  input  logic rst_i,
  input  logic pll_locked_i,  // PLL lock status
  output logic run_o,         // Datapath enable
  output logic dac_rst_o      // DAC reset pin, active high
);

  localparam int unsigned CNT_W = $clog2(SETTLE_CYCLES + 1);

  rp_pkg::startup_state_t state_q;
  rp_pkg::startup_state_t state_d;
  logic [CNT_W-1:0]       settle_cnt_q;  // Cycles already spent in settle
  logic                   settle_done;

  // Last settle cycle
  assign settle_done = (settle_cnt_q == CNT_W'(SETTLE_CYCLES - 1));

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      rp_pkg::ST_WAIT_LOCK: begin
        if (pll_locked_i)
          state_d = rp_pkg::ST_SETTLE;
      end
      rp_pkg::ST_SETTLE: begin
        if (settle_done)
          state_d = rp_pkg::ST_RUN;
      end
      rp_pkg::ST_RUN: state_d = rp_pkg::ST_RUN;
      default:        state_d = rp_pkg::ST_WAIT_LOCK;
    endcase
    // Losing lock always restarts the sequence
    if (!pll_locked_i)
      state_d = rp_pkg::ST_WAIT_LOCK;
  end

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      state_q      <= rp_pkg::ST_WAIT_LOCK;
      settle_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == rp_pkg::ST_SETTLE)
        settle_cnt_q <= settle_cnt_q + 1'b1;
      else
        settle_cnt_q <= '0;  // Fresh count on every settle entry
    end
  end

  assign run_o     = (state_q == rp_pkg::ST_RUN);
  assign dac_rst_o = (state_q != rp_pkg::ST_RUN);  // DAC out of reset only in run

endmodule

// ==== verilog/rp_mix_if.sv ====
// Generator and controller mixing bus
// Carries ASG and PID samples into the DAC back end, saturated sums back out

interface rp_mix_if;

  // Generator samples
  rp_pkg::sample_t asg_a;
  rp_pkg::sample_t asg_b;

  // Controller samples
  rp_pkg::sample_t pid_a;
  rp_pkg::sample_t pid_b;

  // Saturated sums, two's complement
  rp_pkg::sample_t dac_a;
  rp_pkg::sample_t dac_b;

  // Top level drives the sources
  modport src (
    output asg_a, asg_b,
    output pid_a, pid_b
  );

  // DAC back end sums and saturates
  modport mix (
    input  asg_a, asg_b,
    input  pid_a, pid_b,
    output dac_a, dac_b
  );

  // ADC front end taps the sums for loopback
  modport loop (
    input  dac_a, dac_b
  );

endinterface

// ==== verilog/rp_pkg.sv ====
// Converter datapath shared definitions
// Sample widths, sample types and startup sequencer states

package rp_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  localparam int unsigned ADC_RAW_W = 16;  // Full ADC word, 2 reserved LSBs
  localparam int unsigned SMP_W     = 14;  // Converter sample
  localparam int unsigned SUM_W     = 15;  // Generator + controller sum

  //////////////////////////////
  // Sample types
  //////////////////////////////

  // Unconverted ADC word, unsigned negative slope
  typedef logic [ADC_RAW_W-1:0] raw_adc_t;

  // Two's complement sample on acquire and generate paths
  typedef logic signed [SMP_W-1:0] sample_t;

  // DAC code, unsigned negative slope
  typedef logic [SMP_W-1:0] dac_code_t;

  // PWM duty word, also the PWM period counter
  typedef logic [7:0] duty_t;

  //////////////////////////////
  // Startup sequencer
  //////////////////////////////

  typedef enum logic [1:0] {
    ST_WAIT_LOCK,  // PLL not locked, DAC held in reset
    ST_SETTLE,     // Lock seen, waiting for clocks to settle
    ST_RUN         // Datapath live
  } startup_state_t;

endpackage
